/* hw/copy_pkg.sv */
/*
  Shared types for the copy accelerator. Addresses and data are 32-bit words;
  the transfer size field is 10 bits wide, so one transfer moves at most 1020 bytes.
*/
package copy_pkg;

  // Data and address word on both buses
  typedef logic [31:0] word_t;

  // Transfer size in bytes, low two bits ignored by the masters
  typedef logic [9:0] size_t;

  // Register map of the control port
  typedef enum logic [7:0] {
    REG_READ_ADDR  = 8'h00,
    REG_WRITE_ADDR = 8'h04,
    REG_THRESHOLD  = 8'h08,
    REG_READY      = 8'h0C,
    REG_SIZE       = 8'h10,
    REG_START      = 8'h14
  } reg_offset_e;

endpackage

/* hw/copy_ifs.sv */
/*
  Internal interfaces of the copy accelerator. cfg_if carries the programmed
  transfer and the start/done pulses, fifo_if joins both masters to the word FIFO.
*/
`timescale 1ns/1ps

interface cfg_if;
  import copy_pkg::*;

  word_t read_addr;
  word_t write_addr;
  word_t threshold;
  size_t size;
  // One-cycle pulses
  logic  start;
  logic  done;

  modport ctrl (output read_addr, write_addr, threshold, size, start, input done);
  modport reader (input read_addr, size, start);
  modport writer (input write_addr, threshold, start, output done);
endinterface

interface fifo_if;
  import copy_pkg::*;

  logic  push;
  word_t push_data;
  logic  flush;
  logic  full;
  logic  alm_full;
  logic  empty;
  word_t pop_data;
  logic  pop;
  // Reader idle with no read in flight
  logic  reader_drained;

  modport fill (output push, push_data, flush, reader_drained, input full, alm_full);
  modport store (input push, push_data, flush, pop,
                 output full, alm_full, empty, pop_data);
  modport drain (output pop, input empty, pop_data, reader_drained);
endinterface

/* hw/reg_decode.sv */
/*
  Register file and transfer controller. Plain strobes, no handshake; reads are
  combinational. START clears itself once accepted; READY is read-only.
*/
`timescale 1ns/1ps

module reg_decode (
  input  logic            clk_i,
  input  logic            rst_ni,
  input  logic            reg_valid_i,
  input  logic            reg_write_i,
  input  logic [7:0]      reg_addr_i,
  input  copy_pkg::word_t reg_wdata_i,
  output copy_pkg::word_t reg_rdata_o,
  cfg_if.ctrl             cfg
);
  import copy_pkg::*;

  typedef enum logic [1:0] {
    ST_READY,
    ST_STARTING,
    ST_RUNNING
  } ctrl_state_e;

  ctrl_state_e state_q, state_d;
  reg_offset_e offset;
  word_t       read_addr_q;
  word_t       write_addr_q;
  word_t       threshold_q;
  size_t       size_q;
  logic        ready_q;
  logic        start_q;
  logic        start_pending_q;
  logic        reg_wr;
  logic        accept;

  assign offset = reg_offset_e'(reg_addr_i);
  assign reg_wr = reg_valid_i && reg_write_i;
  assign accept = (state_q == ST_READY) && start_pending_q;

  assign cfg.read_addr  = read_addr_q;
  assign cfg.write_addr = write_addr_q;
  assign cfg.threshold  = threshold_q;
  assign cfg.size       = size_q;
  assign cfg.start      = (state_q == ST_STARTING);

  always_comb begin
    reg_rdata_o = '0;
    if (reg_valid_i) begin
      case (offset)
        REG_READ_ADDR:  reg_rdata_o = read_addr_q;
        REG_WRITE_ADDR: reg_rdata_o = write_addr_q;
        REG_THRESHOLD:  reg_rdata_o = threshold_q;
        REG_READY:      reg_rdata_o = {31'b0, ready_q};
        REG_SIZE:       reg_rdata_o = {22'b0, size_q};
        REG_START:      reg_rdata_o = {31'b0, start_q};
        default:        reg_rdata_o = '0;
      endcase
    end
  end

  // Writable registers, READY has no write path
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      read_addr_q  <= '0;
      write_addr_q <= '0;
      threshold_q  <= '0;
      size_q       <= '0;
    end else if (reg_wr) begin
      case (offset)
        REG_READ_ADDR:  read_addr_q <= reg_wdata_i;
        REG_WRITE_ADDR: write_addr_q <= reg_wdata_i;
        REG_THRESHOLD:  threshold_q <= reg_wdata_i;
        REG_SIZE:       size_q <= reg_wdata_i[9:0];
        default:        ;
      endcase
    end
  end

  // A start with less than one word to move is dropped right away
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      start_q         <= 1'b0;
      start_pending_q <= 1'b0;
    end else if (reg_wr && offset == REG_START) begin
      start_q         <= reg_wdata_i[0];
      start_pending_q <= reg_wdata_i[0] && (size_q[9:2] != '0);
    end else if (accept) begin
      start_q         <= 1'b0;
      start_pending_q <= 1'b0;
    end else if (start_q && !start_pending_q) begin
      start_q <= 1'b0;
    end
  end

  // READY -> STARTING (start pulse) -> RUNNING until done
  always_comb begin
    state_d = state_q;
    case (state_q)
      ST_READY:    if (start_pending_q) state_d = ST_STARTING;
      ST_STARTING: state_d = ST_RUNNING;
      ST_RUNNING:  if (cfg.done) state_d = ST_READY;
      default:     state_d = ST_READY;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= ST_READY;
      ready_q <= 1'b0;
    end else begin
      state_q <= state_d;
      ready_q <= (state_d == ST_READY);
    end
  end

endmodule

/* hw/dma_read_master.sv */
/*
  Read master. Assumes read data returns one cycle after the grant, so that
  holding off at almost-full is enough to keep the FIFO from overflowing.
*/
`timescale 1ns/1ps

module dma_read_master #(
  parameter int unsigned FIFO_DEPTH = 4
) (
  input  logic            clk_i,
  input  logic            rst_ni,
  cfg_if.reader           cfg,
  fifo_if.fill            fifo,
  output logic            rd_req_o,
  output copy_pkg::word_t rd_addr_o,
  input  logic            rd_gnt_i,
  input  logic            rd_rvalid_i,
  input  copy_pkg::word_t rd_rdata_i
);
  import copy_pkg::*;

  localparam int unsigned CntW = $clog2(FIFO_DEPTH + 1);
  localparam logic [CntW-1:0] CntOne = CntW'(1);

  typedef enum logic {
    RD_IDLE,
    RD_ON
  } rd_state_e;

  rd_state_e       state_q, state_d;
  word_t           rd_ptr_q;
  size_t           byte_cnt_q;
  logic [CntW-1:0] outstanding_q;
  logic            rd_fire;

  assign rd_fire   = rd_req_o && rd_gnt_i;
  assign rd_addr_o = rd_ptr_q;

  // Every returned word goes straight into the FIFO
  assign fifo.push           = rd_rvalid_i;
  assign fifo.push_data      = rd_rdata_i;
  assign fifo.reader_drained = (state_q == RD_IDLE) && (outstanding_q == '0);

  always_comb begin
    state_d    = state_q;
    rd_req_o   = 1'b0;
    fifo.flush = 1'b0;
    case (state_q)
      RD_IDLE: begin
        if (cfg.start) begin
          state_d    = RD_ON;
          fifo.flush = 1'b1;
        end
      end
      RD_ON: begin
        if (byte_cnt_q == '0) begin
          state_d = RD_IDLE;
        end else if (!fifo.full && !fifo.alm_full) begin
          rd_req_o = 1'b1;
        end
      end
      default: state_d = RD_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= RD_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Pointer and remaining bytes, both step by one word per grant
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rd_ptr_q   <= '0;
      byte_cnt_q <= '0;
    end else if (cfg.start && state_q == RD_IDLE) begin
      rd_ptr_q   <= cfg.read_addr;
      byte_cnt_q <= {cfg.size[9:2], 2'b00};
    end else if (rd_fire) begin
      rd_ptr_q   <= rd_ptr_q + 32'd4;
      byte_cnt_q <= byte_cnt_q - 10'd4;
    end
  end

  // Reads granted but not yet returned
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      outstanding_q <= '0;
    end else begin
      case ({rd_fire, rd_rvalid_i})
        2'b10:   outstanding_q <= outstanding_q + CntOne;
        2'b01:   outstanding_q <= outstanding_q - CntOne;
        default: ;
      endcase
    end
  end

endmodule

/* hw/word_fifo.sv */
/*
  Circular word FIFO, FIFO_DEPTH of 2 or more. Push when full and pop when
  empty are ignored. Flush empties it in one cycle and wins over push and pop.
*/
`timescale 1ns/1ps

module word_fifo #(
  parameter int unsigned FIFO_DEPTH = 4
) (
  input  logic  clk_i,
  input  logic  rst_ni,
  fifo_if.store fifo
);
  import copy_pkg::*;

  localparam int unsigned PtrW   = $clog2(FIFO_DEPTH);
  localparam int unsigned UsageW = $clog2(FIFO_DEPTH + 1);
  localparam logic [PtrW-1:0]   LastPtr  = PtrW'(FIFO_DEPTH - 1);
  localparam logic [PtrW-1:0]   PtrOne   = PtrW'(1);
  localparam logic [UsageW-1:0] UsageOne = UsageW'(1);
  localparam logic [UsageW-1:0] FullUse  = UsageW'(FIFO_DEPTH);
  localparam logic [UsageW-1:0] AlmUse   = UsageW'(FIFO_DEPTH - 1);

  word_t             mem_q [FIFO_DEPTH];
  logic [PtrW-1:0]   wr_ptr_q, rd_ptr_q;
  logic [UsageW-1:0] usage_q;
  logic              do_push, do_pop;

  function automatic logic [PtrW-1:0] ptr_inc(logic [PtrW-1:0] ptr);
    if (ptr == LastPtr) begin
      return '0;
    end
    return ptr + PtrOne;
  endfunction

  assign fifo.full     = (usage_q == FullUse);
  assign fifo.alm_full = (usage_q == AlmUse);
  assign fifo.empty    = (usage_q == '0);
  assign fifo.pop_data = mem_q[rd_ptr_q];

  assign do_push = fifo.push && !fifo.full;
  assign do_pop  = fifo.pop && !fifo.empty;

  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem_q[wr_ptr_q] <= fifo.push_data;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      usage_q  <= '0;
    end else if (fifo.flush) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      usage_q  <= '0;
    end else begin
      if (do_push) wr_ptr_q <= ptr_inc(wr_ptr_q);
      if (do_pop) rd_ptr_q <= ptr_inc(rd_ptr_q);
      case ({do_push, do_pop})
        2'b10:   usage_q <= usage_q + UsageOne;
        2'b01:   usage_q <= usage_q - UsageOne;
        default: ;
      endcase
    end
  end

endmodule

/* hw/dma_write_master.sv */
/*
  Write master. Words below the threshold (unsigned) are written as zero.
  The threshold is sampled at start and holds for the whole transfer.
*/
`timescale 1ns/1ps

module dma_write_master (
  input  logic            clk_i,
  input  logic            rst_ni,
  cfg_if.writer           cfg,
  fifo_if.drain           fifo,
  output logic            wr_req_o,
  output copy_pkg::word_t wr_addr_o,
  output copy_pkg::word_t wr_wdata_o,
  input  logic            wr_gnt_i
);
  import copy_pkg::*;

  typedef enum logic {
    WR_IDLE,
    WR_ON
  } wr_state_e;

  wr_state_e state_q, state_d;
  word_t     wr_ptr_q;
  word_t     threshold_q;
  logic      wr_fire;

  assign wr_req_o  = (state_q == WR_ON) && !fifo.empty;
  assign wr_fire   = wr_req_o && wr_gnt_i;
  assign fifo.pop  = wr_fire;
  assign wr_addr_o = wr_ptr_q;

  // Threshold filter on the head word
  assign wr_wdata_o = (fifo.pop_data >= threshold_q) ? fifo.pop_data : '0;

  // Finished once nothing is buffered and nothing more can arrive
  assign cfg.done = (state_q == WR_ON) && fifo.empty && fifo.reader_drained;

  always_comb begin
    state_d = state_q;
    case (state_q)
      WR_IDLE: if (cfg.start) state_d = WR_ON;
      WR_ON:   if (cfg.done) state_d = WR_IDLE;
      default: state_d = WR_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q  <= WR_IDLE;
      wr_ptr_q <= '0;
    end else begin
      state_q <= state_d;
      if (cfg.start && state_q == WR_IDLE) begin
        wr_ptr_q <= cfg.write_addr;
      end else if (wr_fire) begin
        wr_ptr_q <= wr_ptr_q + 32'd4;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (cfg.start && state_q == WR_IDLE) begin
      threshold_q <= cfg.threshold;
    end
  end

endmodule

/* hw/copy_accel_top.sv */
/*
  Copy accelerator with threshold filter. Full-word transfers only, no error
  responses; read data is expected one cycle after each read grant.
*/
`timescale 1ns/1ps

module copy_accel_top #(
  parameter int unsigned FIFO_DEPTH = 4
) (
  input  logic            clk_i,
  input  logic            rst_ni,
  // Register port
  input  logic            reg_valid_i,
  input  logic            reg_write_i,
  input  logic [7:0]      reg_addr_i,
  input  copy_pkg::word_t reg_wdata_i,
  output copy_pkg::word_t reg_rdata_o,
  // Read bus
  output logic            rd_req_o,
  output copy_pkg::word_t rd_addr_o,
  input  logic            rd_gnt_i,
  input  logic            rd_rvalid_i,
  input  copy_pkg::word_t rd_rdata_i,
  // Write bus
  output logic            wr_req_o,
  output copy_pkg::word_t wr_addr_o,
  output copy_pkg::word_t wr_wdata_o,
  input  logic            wr_gnt_i
);

  cfg_if  cfg_bus ();
  fifo_if fifo_bus ();

  reg_decode u_reg_decode (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .reg_valid_i (reg_valid_i),
    .reg_write_i (reg_write_i),
    .reg_addr_i  (reg_addr_i),
    .reg_wdata_i (reg_wdata_i),
    .reg_rdata_o (reg_rdata_o),
    .cfg         (cfg_bus)
  );

  dma_read_master #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) u_read_master (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .cfg         (cfg_bus),
    .fifo        (fifo_bus),
    .rd_req_o    (rd_req_o),
    .rd_addr_o   (rd_addr_o),
    .rd_gnt_i    (rd_gnt_i),
    .rd_rvalid_i (rd_rvalid_i),
    .rd_rdata_i  (rd_rdata_i)
  );

  word_fifo #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) u_word_fifo (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .fifo   (fifo_bus)
  );

  dma_write_master u_write_master (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .cfg        (cfg_bus),
    .fifo       (fifo_bus),
    .wr_req_o   (wr_req_o),
    .wr_addr_o  (wr_addr_o),
    .wr_wdata_o (wr_wdata_o),
    .wr_gnt_i   (wr_gnt_i)
  );

endmodule

/* tb/mem_model.sv */
/*
  Behavioral memory behind both buses, one array of WORDS words, refilled while
  reset is low. Grants are random at gnt_pct_i percent, read data follows one
  cycle after each read grant. Reads and writes to one word in one cycle are not ordered.
*/
`timescale 1ns/1ps

module mem_model #(
  parameter int unsigned WORDS = 1024
) (
  input  logic        clk_i,
  input  logic        rst_ni,
  input  int unsigned gnt_pct_i,
  input  logic        rd_req_i,
  input  logic [31:0] rd_addr_i,
  output logic        rd_gnt_o,
  output logic        rd_rvalid_o,
  output logic [31:0] rd_rdata_o,
  input  logic        wr_req_i,
  input  logic [31:0] wr_addr_i,
  input  logic [31:0] wr_wdata_i,
  output logic        wr_gnt_o
);
  localparam int unsigned IdxW = $clog2(WORDS);

  logic [31:0] mem [WORDS];
  integer      seed = 32'hc5faf4a0;
  logic        rd_gnt_q = 1'b0;
  logic        wr_gnt_q = 1'b0;
  logic        rvalid_q = 1'b0;
  logic [31:0] rdata_q = 32'd0;
  // Transfers that happen at the coming rising edge
  logic        rd_fire_q = 1'b0;
  logic        wr_fire_q = 1'b0;
  logic [31:0] rd_addr_q = 32'd0;
  logic [31:0] wr_addr_q = 32'd0;
  logic [31:0] wr_data_q = 32'd0;

  assign rd_gnt_o    = rd_gnt_q;
  assign wr_gnt_o    = wr_gnt_q;
  assign rd_rvalid_o = rvalid_q;
  assign rd_rdata_o  = rdata_q;

  always @(negedge clk_i) begin : bus_drive
    logic rd_roll;
    logic wr_roll;
    if (!rst_ni) begin
      // Fill pattern from the whole word index
      for (int i = 0; i < WORDS; i++) begin
        mem[i] = (32'(i) * 32'h9e37_79b1) ^ 32'h5ac3_0f1e;
      end
      rd_gnt_q  <= 1'b0;
      wr_gnt_q  <= 1'b0;
      rvalid_q  <= 1'b0;
      rd_fire_q <= 1'b0;
      wr_fire_q <= 1'b0;
    end else begin
      // Complete the transfers of the edge that just passed
      rvalid_q <= rd_fire_q;
      if (rd_fire_q) begin
        rdata_q <= mem[rd_addr_q[IdxW+1:2]];
      end
      if (wr_fire_q) begin
        mem[wr_addr_q[IdxW+1:2]] = wr_data_q;
      end
      rd_roll = ($unsigned($random(seed)) % 32'd100) < gnt_pct_i;
      wr_roll = ($unsigned($random(seed)) % 32'd100) < gnt_pct_i;
      rd_gnt_q  <= rd_roll;
      wr_gnt_q  <= wr_roll;
      rd_fire_q <= rd_req_i && rd_roll;
      wr_fire_q <= wr_req_i && wr_roll;
      rd_addr_q <= rd_addr_i;
      wr_addr_q <= wr_addr_i;
      wr_data_q <= wr_wdata_i;
    end
  end

endmodule

/* tb/tb_copy_accel.sv */
/*
  Directed tests for copy_accel_top against a 4 KB memory model. Test regions
  do not overlap; expected words come from source snapshots taken before each copy.
*/
`timescale 1ns/1ps

module tb_copy_accel;
  import copy_pkg::*;

  localparam int unsigned ClkPeriod = 40;
  localparam int unsigned ResetCycles = 8;
  // Longest copy is 32 words at 30% grants on both buses, about 250 cycles;
  // all six tests with register polling stay near 1000 cycles
  localparam int unsigned TimeoutCycles = 5000;

  logic        clk = 1'b0;
  logic        rst_n;
  logic        reg_valid;
  logic        reg_we;
  logic [7:0]  reg_addr;
  word_t       reg_wdata;
  word_t       reg_rdata;
  logic        rd_req, rd_gnt, rd_rvalid;
  word_t       rd_addr, rd_rdata;
  logic        wr_req, wr_gnt;
  word_t       wr_addr, wr_wdata;
  int unsigned gnt_pct;
  int unsigned cycles = 0;
  int          errors = 0;
  int          tests_run = 0;
  int          tests_failed = 0;
  word_t       snap [$];

  always #(ClkPeriod / 2) clk = ~clk;

  copy_accel_top #(
    .FIFO_DEPTH (4)
  ) dut0 (
    .clk_i       (clk),
    .rst_ni      (rst_n),
    .reg_valid_i (reg_valid),
    .reg_write_i (reg_we),
    .reg_addr_i  (reg_addr),
    .reg_wdata_i (reg_wdata),
    .reg_rdata_o (reg_rdata),
    .rd_req_o    (rd_req),
    .rd_addr_o   (rd_addr),
    .rd_gnt_i    (rd_gnt),
    .rd_rvalid_i (rd_rvalid),
    .rd_rdata_i  (rd_rdata),
    .wr_req_o    (wr_req),
    .wr_addr_o   (wr_addr),
    .wr_wdata_o  (wr_wdata),
    .wr_gnt_i    (wr_gnt)
  );

  mem_model #(
    .WORDS (1024)
  ) mem0 (
    .clk_i       (clk),
    .rst_ni      (rst_n),
    .gnt_pct_i   (gnt_pct),
    .rd_req_i    (rd_req),
    .rd_addr_i   (rd_addr),
    .rd_gnt_o    (rd_gnt),
    .rd_rvalid_o (rd_rvalid),
    .rd_rdata_o  (rd_rdata),
    .wr_req_i    (wr_req),
    .wr_addr_i   (wr_addr),
    .wr_wdata_i  (wr_wdata),
    .wr_gnt_o    (wr_gnt)
  );

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= TimeoutCycles) begin
      $display("Timeout: the tests did not finish within %0d cycles", TimeoutCycles);
      $display("Test failures found");
      $finish;
    end
  end

  function automatic word_t mem_word(word_t addr);
    return mem0.mem[addr[11:2]];
  endfunction

  // Words under the threshold are written as zero
  function automatic word_t filtered(word_t value, word_t thr);
    return (value >= thr) ? value : 32'd0;
  endfunction

  task automatic check_value(input string name, input word_t got, input word_t exp);
    assert (got === exp) else begin
      $display("CHECK FAILED at time %0t: %s = 0x%08h, expected 0x%08h", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic reg_write(input reg_offset_e addr, input word_t data);
    @(negedge clk);
    reg_valid = 1'b1;
    reg_we    = 1'b1;
    reg_addr  = addr;
    reg_wdata = data;
    @(negedge clk);
    reg_valid = 1'b0;
    reg_we    = 1'b0;
  endtask

  task automatic reg_read(input reg_offset_e addr, output word_t data);
    @(negedge clk);
    reg_valid = 1'b1;
    reg_we    = 1'b0;
    reg_addr  = addr;
    #(ClkPeriod / 4);
    data = reg_rdata;
    @(negedge clk);
    reg_valid = 1'b0;
  endtask

  task automatic reg_read_check(input reg_offset_e addr, input word_t exp);
    word_t got;
    reg_read(addr, got);
    check_value(addr.name(), got, exp);
  endtask

  task automatic snapshot(input word_t addr, input int words);
    snap.delete();
    for (int i = 0; i < words; i++) begin
      snap.push_back(mem_word(addr + 32'(4 * i)));
    end
  endtask

  // Compares a region with the filtered snapshot
  task automatic check_dest(input word_t dst, input word_t thr, input int words);
    word_t addr;
    for (int i = 0; i < words; i++) begin
      addr = dst + 32'(4 * i);
      check_value($sformatf("mem[0x%03h]", addr), mem_word(addr), filtered(snap[i], thr));
    end
  endtask

  task automatic run_copy(input word_t src, input word_t dst, input word_t thr,
                          input word_t bytes);
    word_t ready;
    reg_write(REG_READ_ADDR, src);
    reg_write(REG_WRITE_ADDR, dst);
    reg_write(REG_THRESHOLD, thr);
    reg_write(REG_SIZE, bytes);
    reg_write(REG_START, 32'd1);
    // READY drops once the start is accepted and rises again after done
    ready = 32'd1;
    while (ready != 32'd0) begin
      reg_read(REG_READY, ready);
    end
    while (ready != 32'd1) begin
      reg_read(REG_READY, ready);
    end
  endtask

  task automatic finish_test(input string name, input int err_start);
    tests_run++;
    if (errors == err_start) begin
      $display("%-22s passed", name);
    end else begin
      tests_failed++;
      $display("%-22s FAILED with %0d errors", name, errors - err_start);
    end
  endtask

  task automatic reset_values();
    int err_start = errors;
    reg_read_check(REG_READ_ADDR, 32'd0);
    reg_read_check(REG_WRITE_ADDR, 32'd0);
    reg_read_check(REG_THRESHOLD, 32'd0);
    reg_read_check(REG_READY, 32'd1);
    reg_read_check(REG_SIZE, 32'd0);
    reg_read_check(REG_START, 32'd0);
    finish_test("reset values", err_start);
  endtask

  task automatic register_round_trip();
    int err_start = errors;
    reg_write(REG_READ_ADDR, 32'h1234_5678);
    reg_write(REG_WRITE_ADDR, 32'h9abc_def0);
    reg_write(REG_THRESHOLD, 32'h0f0f_a5a5);
    reg_write(REG_SIZE, 32'hffff_f2a4);
    reg_read_check(REG_READ_ADDR, 32'h1234_5678);
    reg_read_check(REG_WRITE_ADDR, 32'h9abc_def0);
    reg_read_check(REG_THRESHOLD, 32'h0f0f_a5a5);
    // Size field is 10 bits
    reg_read_check(REG_SIZE, 32'h0000_02a4);
    finish_test("register round trip", err_start);
  endtask

  task automatic plain_copy();
    int err_start = errors;
    snapshot(32'h000, 16);
    run_copy(32'h000, 32'h400, 32'd0, 32'd64);
    check_dest(32'h400, 32'd0, 16);
    check_dest(32'h000, 32'd0, 16);
    finish_test("plain copy", err_start);
  endtask

  task automatic threshold_copy();
    int err_start = errors;
    snapshot(32'h100, 16);
    run_copy(32'h100, 32'h500, 32'h8000_0000, 32'd64);
    check_dest(32'h500, 32'h8000_0000, 16);
    finish_test("threshold filter", err_start);
  endtask

  task automatic backpressure_copy();
    int err_start = errors;
    @(negedge clk);
    gnt_pct = 30;
    snapshot(32'h200, 32);
    run_copy(32'h200, 32'h600, 32'd0, 32'd128);
    check_dest(32'h600, 32'd0, 32);
    reg_read_check(REG_READY, 32'd1);
    @(negedge clk);
    gnt_pct = 100;
    finish_test("back-pressure copy", err_start);
  endtask

  task automatic zero_size_start();
    int err_start = errors;
    snapshot(32'h700, 16);
    reg_write(REG_READ_ADDR, 32'h300);
    reg_write(REG_WRITE_ADDR, 32'h700);
    reg_write(REG_SIZE, 32'd0);
    reg_write(REG_START, 32'd1);
    // READY holds and nothing moves on either bus
    repeat (4) begin
      reg_read_check(REG_READY, 32'd1);
      assert (!rd_req && !wr_req) else begin
        $display("Bus request seen at time %0t after START with size zero", $time);
        errors++;
      end
    end
    reg_read_check(REG_START, 32'd0);
    check_dest(32'h700, 32'd0, 16);
    finish_test("size zero start", err_start);
  endtask

  initial begin
    rst_n     = 1'b0;
    reg_valid = 1'b0;
    reg_we    = 1'b0;
    reg_addr  = 8'h00;
    reg_wdata = 32'd0;
    gnt_pct   = 100;
    repeat (ResetCycles) @(negedge clk);
    rst_n = 1'b1;
    reset_values();
    register_round_trip();
    plain_copy();
    threshold_copy();
    backpressure_copy();
    zero_size_start();
    $display("Summary: %0d tests, %0d failed, %0d check errors",
             tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

/* tb.f */
hw/copy_pkg.sv
hw/copy_ifs.sv
hw/reg_decode.sv
hw/dma_read_master.sv
hw/word_fifo.sv
hw/dma_write_master.sv
hw/copy_accel_top.sv
tb/mem_model.sv
tb/tb_copy_accel.sv

/* run_verilator.sh */
#!/bin/sh
# Builds the copy accelerator testbench with Verilator and runs it.
# Exit status is 0 only when the log holds the pass line.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
  --top-module tb_copy_accel -f tb.f -o sim_copy_accel

./obj_dir/sim_copy_accel | tee sim.log

if grep -qxF 'All tests passed!' sim.log; then
  exit 0
fi
exit 1
